/* Makefile */
VERILATOR ?= verilator
TOP ?= tbApbI2c
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= all tests passed
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o simv
	-$(BUILD_DIR)/simv | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation FAILED"; exit 1; }
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/i2cSlaveModel.sv */
// Behavioral I2C slave for the testbench, captures written bytes and returns programmed read bytes
`timescale 1ns/1ps

module i2cSlaveModel import i2cPkg::*;
(
	input  logic        scl,
	input  logic        sda,
	input  logic        ackAddr,
	input  logic [31:0] readWord,
	output logic        sdaLow,
	output slaveAddr_t  seenAddr,
	output logic        seenRead,
	output logic [31:0] wrWord,
	output int          wrCount,
	output logic        sawNack
);
	// Mode 0 idle, 1 address, 2 write data, 3 read data
	int mode;
	// Bit position in the current byte, 8 is the acknowledge slot
	int bitIdx;
	int rdIdx;
	logic skipFall;
	i2cByte_t shift;
	i2cByte_t outByte;

	initial
	begin
		sdaLow = 1'b0;
		mode = 0;
		bitIdx = 0;
		rdIdx = 0;
		skipFall = 1'b0;
		shift = '0;
		outByte = '0;
		seenAddr = '0;
		seenRead = 1'b0;
		wrWord = '0;
		wrCount = 0;
		sawNack = 1'b0;
	end

	////////////////////////////////////////////////////////////
	// START and STOP, SDA edges while SCL is high
	////////////////////////////////////////////////////////////
	always @(negedge sda)
	begin
		if (scl === 1'b1)
		begin
			mode = 1;
			bitIdx = 0;
			rdIdx = 0;
			// The SCL fall after START ends no bit
			skipFall = 1'b1;
			wrCount = 0;
			wrWord = '0;
			sawNack = 1'b0;
		end
	end

	always @(posedge sda)
	begin
		if (scl === 1'b1)
		begin
			mode = 0;
			sdaLow = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Bit sampling on rising SCL
	////////////////////////////////////////////////////////////
	always @(posedge scl)
	begin
		if (mode != 0 && bitIdx < 8 && mode != 3)
			shift = {shift[6:0], sda};
		else if (mode == 3 && bitIdx == 8 && sda === 1'b1)
		begin
			// Master refused further data
			sawNack = 1'b1;
			mode = 0;
		end
	end

	// Output changes only while SCL is low
	always @(negedge scl)
	begin
		if (skipFall)
			skipFall = 1'b0;
		else if (mode != 0)
		begin
			if (bitIdx < 7)
			begin
				bitIdx++;
				if (mode == 3)
					sdaLow = !outByte[7 - bitIdx];
			end
			else if (bitIdx == 7)
			begin
				bitIdx = 8;
				case (mode)
					1:
					begin
						seenAddr = shift[7:1];
						seenRead = shift[0];
						sdaLow = ackAddr;
						if (!ackAddr)
							mode = 0;
					end
					2:
					begin
						wrWord[8*wrCount +: 8] = shift;
						wrCount++;
						sdaLow = 1'b1;
					end
					// Release for the master acknowledge
					default: sdaLow = 1'b0;
				endcase
			end
			else
			begin
				// Acknowledge slot over
				bitIdx = 0;
				sdaLow = 1'b0;
				if (mode == 1)
					mode = seenRead ? 3 : 2;
				if (mode == 3)
				begin
					outByte = readWord[8*rdIdx +: 8];
					rdIdx++;
					sdaLow = !outByte[7];
				end
			end
		end
	end

endmodule

/* sim/tbApbI2c.sv */
// Testbench of the APB I2C master, runs a table of transfers against the slave model
`timescale 1ns/1ps

module tbApbI2c import i2cPkg::*;
;
	localparam int POLL_LIMIT = 5000;
	localparam int SCL_LIMIT = 2000;
	localparam int NUM_ROWS = 6;

	// One transfer, bytes packed with the first byte in bits 7..0
	typedef struct {
		slaveAddr_t  addr;
		logic        rd;
		byteCount_t  count;
		logic [31:0] bytes;
		logic        ack;
		divider_t    div;
		logic        expNack;
	} row_t;

	logic PCLK;
	logic PRESETn;
	apbReq_t apbReq;
	apbData_t PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic intTx;
	logic intRx;
	logic sclLow;
	logic sdaLow;
	// Open-drain bus lines
	logic sclLine;
	logic sdaLine;
	logic slaveSdaLow;
	logic ackAddr;
	logic [31:0] readWord;
	slaveAddr_t seenAddr;
	logic seenRead;
	logic [31:0] wrWord;
	int wrCount;
	logic sawNack;
	row_t rows [NUM_ROWS];
	int seed;

	assign sclLine = !sclLow;
	assign sdaLine = !(sdaLow || slaveSdaLow);

	apbI2cTop #(.FIFO_DEPTH(4)) DUT (
		.PCLK(PCLK), .PRESETn(PRESETn), .apbReq(apbReq), .sdaIn(sdaLine),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR), .intTx(intTx),
		.intRx(intRx), .sclLow(sclLow), .sdaLow(sdaLow)
	);

	i2cSlaveModel slave (
		.scl(sclLine), .sda(sdaLine), .ackAddr(ackAddr), .readWord(readWord),
		.sdaLow(slaveSdaLow), .seenAddr(seenAddr), .seenRead(seenRead),
		.wrWord(wrWord), .wrCount(wrCount), .sawNack(sawNack)
	);

	always #4 PCLK = ~PCLK;

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic abortRun();
		$display("tests failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkByte(input string name, input i2cByte_t exp, input i2cByte_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkData(input string name, input apbData_t exp, input apbData_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
			abortRun();
		end
	endtask

	////////////////////////////////////////////////////////////
	// APB access, setup then one access cycle
	////////////////////////////////////////////////////////////
	task automatic apbAccess(input logic wr, input apbAddr_t addr, input apbData_t wdata,
		output apbData_t rdata, output logic err);
		@(negedge PCLK);
		apbReq.sel = 1'b1;
		apbReq.enable = 1'b0;
		apbReq.write = wr;
		apbReq.addr = addr;
		apbReq.wdata = wdata;
		@(negedge PCLK);
		apbReq.enable = 1'b1;
		// Sample well clear of both edges
		#2;
		checkBit("PREADY in access phase", 1'b1, PREADY);
		rdata = PRDATA;
		err = PSLVERR;
		@(negedge PCLK);
		apbReq = '0;
	endtask

	task automatic regWrite(input string name, input apbAddr_t addr, input apbData_t data);
		apbData_t unused;
		logic err;
		apbAccess(1'b1, addr, data, unused, err);
		checkBit({name, " write PSLVERR"}, 1'b0, err);
	endtask

	task automatic regRead(input string name, input apbAddr_t addr, output apbData_t data);
		logic err;
		apbAccess(1'b0, addr, '0, data, err);
		checkBit({name, " read PSLVERR"}, 1'b0, err);
	endtask

	// CONFIG layout: start, read, address, byte count
	function automatic apbData_t configWord(slaveAddr_t addr, logic rd, byteCount_t count,
		logic start);
		return {19'd0, count, addr, rd, start};
	endfunction

	////////////////////////////////////////////////////////////
	// Waits, each bounded
	////////////////////////////////////////////////////////////
	task automatic waitIdle(input string name, output apbData_t status);
		int polls;
		polls = 0;
		regRead(name, STATUS_ADDR, status);
		while (status[0])
		begin
			polls++;
			if (polls > POLL_LIMIT)
			begin
				$display("Timeout: busy never fell in %s", name);
				abortRun();
			end
			regRead(name, STATUS_ADDR, status);
		end
	endtask

	task automatic waitSclRise(input string name, output int cycles);
		logic prev;
		logic seen;
		cycles = 0;
		prev = sclLine;
		seen = 1'b0;
		while (!seen)
		begin
			@(negedge PCLK);
			cycles++;
			if (cycles > SCL_LIMIT)
			begin
				$display("Timeout: no rising SCL edge in %s", name);
				abortRun();
			end
			seen = !prev && sclLine;
			prev = sclLine;
		end
	endtask

	// Start a transfer and measure one address bit of SCL
	task automatic startTransfer(input string name, input row_t row);
		int skipped;
		int period;
		regWrite(name, CONFIG_ADDR, configWord(row.addr, row.rd, row.count, 1'b1));
		waitSclRise(name, skipped);
		waitSclRise(name, period);
		checkData({name, " SCL period"}, apbData_t'(4 * (row.div + 1)), apbData_t'(period));
	endtask

	task automatic checkWritten(input string name, input row_t row);
		checkByte({name, " address byte"}, {row.addr, 1'b0}, {seenAddr, seenRead});
		checkData({name, " bytes written"}, apbData_t'(row.count), apbData_t'(wrCount));
		for (int i = 0; i < row.count; i++)
			checkByte({name, " written byte"}, row.bytes[8*i +: 8], wrWord[8*i +: 8]);
	endtask

	////////////////////////////////////////////////////////////
	// Error accesses, the held bytes are sent afterwards
	////////////////////////////////////////////////////////////
	task automatic errorAccesses();
		row_t drain;
		apbData_t data;
		logic err;
		drain = '{7'h2B, 1'b0, 4'd4, 32'h0, 1'b1, 14'd1, 1'b0};
		drain.bytes = $random(seed);
		regRead("reset", STATUS_ADDR, data);
		checkData("reset STATUS", 32'h0000000C, data);
		regWrite("fill", DIVIDER_ADDR, apbData_t'(drain.div));
		for (int i = 0; i < 4; i++)
			regWrite("fill", TX_DATA_ADDR, apbData_t'(drain.bytes[8*i +: 8]));
		regRead("fill", STATUS_ADDR, data);
		checkData("full STATUS", 32'h00000008, data);
		checkBit("intTx with TX data", 1'b0, intTx);
		apbAccess(1'b1, TX_DATA_ADDR, 32'h5A, data, err);
		checkBit("push into full TX PSLVERR", 1'b1, err);
		regRead("overflow", STATUS_ADDR, data);
		checkData("STATUS after overflow", 32'h00000008, data);
		apbAccess(1'b0, RX_DATA_ADDR, '0, data, err);
		checkBit("pop of empty RX PSLVERR", 1'b1, err);
		regRead("underflow", STATUS_ADDR, data);
		checkData("STATUS after underflow", 32'h00000008, data);
		apbAccess(1'b1, 32'd20, 32'h1, data, err);
		checkBit("write offset 20 PSLVERR", 1'b1, err);
		apbAccess(1'b0, 32'd20, '0, data, err);
		checkBit("read offset 20 PSLVERR", 1'b1, err);
		regRead("unmapped", STATUS_ADDR, data);
		checkData("STATUS after unmapped", 32'h00000008, data);
		@(negedge PCLK);
		ackAddr = 1'b1;
		startTransfer("drain", drain);
		waitIdle("drain", data);
		checkWritten("drain", drain);
		checkBit("intTx after drain", 1'b1, intTx);
	endtask

	////////////////////////////////////////////////////////////
	// One table row
	////////////////////////////////////////////////////////////
	task automatic runRow(input int idx);
		row_t row;
		string name;
		apbData_t status;
		apbData_t data;
		row = rows[idx];
		name = $sformatf("row %0d", idx);
		@(negedge PCLK);
		ackAddr = row.ack;
		readWord = row.bytes;
		regWrite(name, DIVIDER_ADDR, apbData_t'(row.div));
		regRead(name, DIVIDER_ADDR, data);
		checkData({name, " DIVIDER readback"}, apbData_t'(row.div), data);
		if (!row.rd)
			for (int i = 0; i < row.count; i++)
				regWrite(name, TX_DATA_ADDR, apbData_t'(row.bytes[8*i +: 8]));
		startTransfer(name, row);
		waitIdle(name, status);
		checkBit({name, " NACK"}, row.expNack, status[1]);
		checkByte({name, " address byte"}, {row.addr, row.rd}, {seenAddr, seenRead});
		if (row.expNack)
		begin
			checkBit({name, " TX empty after NACK"}, 1'b0, status[2]);
			regWrite(name, CONFIG_ADDR, configWord(row.addr, 1'b0, row.count, 1'b0));
			regRead(name, STATUS_ADDR, status);
			checkBit({name, " NACK cleared"}, 1'b0, status[1]);
			// Start is a strobe, only the stored fields read back
			regRead(name, CONFIG_ADDR, data);
			checkData({name, " CONFIG readback"},
				configWord(row.addr, 1'b0, row.count, 1'b0), data & 32'hFFFFFFFE);
			// Held bytes go out to a slave that answers
			@(negedge PCLK);
			ackAddr = 1'b1;
			startTransfer(name, row);
			waitIdle(name, status);
			checkWritten(name, row);
		end
		else if (!row.rd)
			checkWritten(name, row);
		else
		begin
			for (int i = 0; i < row.count; i++)
			begin
				checkBit({name, " intRx before pop"}, 1'b1, intRx);
				regRead(name, RX_DATA_ADDR, data);
				checkByte({name, " read byte"}, row.bytes[8*i +: 8], data[7:0]);
			end
			checkBit({name, " intRx after last pop"}, 1'b0, intRx);
			checkBit({name, " NACK on last byte"}, 1'b1, sawNack);
		end
		regRead(name, STATUS_ADDR, status);
		checkData({name, " final STATUS"}, 32'h0000000C, status);
	endtask

	initial
	begin
		PCLK = 1'b0;
		PRESETn = 1'b0;
		apbReq = '0;
		ackAddr = 1'b1;
		readWord = '0;
		seed = 32'hdb4d;
		// Address, read, count, bytes, model ACK, divider, expected NACK
		rows[0] = '{7'h50, 1'b0, 4'd2, 32'h0, 1'b1, 14'd1, 1'b0};
		rows[1] = '{7'h23, 1'b1, 4'd3, 32'h0, 1'b1, 14'd2, 1'b0};
		rows[2] = '{7'h3A, 1'b0, 4'd4, 32'h0, 1'b1, 14'd3, 1'b0};
		rows[3] = '{7'h11, 1'b0, 4'd2, 32'h0, 1'b0, 14'd1, 1'b1};
		rows[4] = '{7'h6C, 1'b1, 4'd4, 32'h0, 1'b1, 14'd1, 1'b0};
		rows[5] = '{7'h45, 1'b1, 4'd1, 32'h0, 1'b1, 14'd2, 1'b0};
		for (int i = 0; i < NUM_ROWS; i++)
			rows[i].bytes = $random(seed);
		repeat (4) @(posedge PCLK);
		@(negedge PCLK);
		PRESETn = 1'b1;
		@(negedge PCLK);
		checkBit("reset intTx", 1'b1, intTx);
		checkBit("reset intRx", 1'b0, intRx);
		checkBit("idle PREADY", 1'b0, PREADY);
		checkBit("idle PSLVERR", 1'b0, PSLVERR);
		checkBit("reset SCL released", 1'b0, sclLow);
		checkBit("reset SDA released", 1'b0, sdaLow);
		errorAccesses();
		for (int i = 0; i < NUM_ROWS; i++)
			runRow(i);
		$display("all tests passed");
		$finish;
	end

endmodule

/* source/apbI2cTop.sv */
// Top level of the APB I2C master, instantiated by the testbench with open-drain SCL and SDA
`timescale 1ns/1ps

module apbI2cTop import i2cPkg::*;
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic     PCLK,
	input  logic     PRESETn,
	input  apbReq_t  apbReq,
	input  logic     sdaIn,
	output apbData_t PRDATA,
	output logic     PREADY,
	output logic     PSLVERR,
	output logic     intTx,
	output logic     intRx,
	output logic     sclLow,
	output logic     sdaLow
);
	// Transmit path
	logic txPush;
	logic txPop;
	logic txFull;
	logic txEmpty;
	i2cByte_t txInByte;
	i2cByte_t txHeadByte;
	// Receive path
	logic rxPush;
	logic rxPop;
	logic rxFull;
	logic rxEmpty;
	i2cByte_t rxInByte;
	i2cByte_t rxHeadByte;
	// Control between registers and master
	logic startPulse;
	logic run;
	logic tick;
	i2cCmd_t cmd;
	i2cStatus_t status;
	divider_t divider;

	////////////////////////////////////////////////////////////
	// Register block
	////////////////////////////////////////////////////////////
	apbRegs regs (
		.PCLK(PCLK), .PRESETn(PRESETn), .apbReq(apbReq), .rxByte(rxHeadByte),
		.txFull(txFull), .txEmpty(txEmpty), .rxFull(rxFull), .rxEmpty(rxEmpty),
		.status(status), .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.txPush(txPush), .txByte(txInByte), .rxPop(rxPop), .startPulse(startPulse),
		.cmd(cmd), .divider(divider), .intTx(intTx), .intRx(intRx)
	);

	////////////////////////////////////////////////////////////
	// FIFOs, same depth both ways
	////////////////////////////////////////////////////////////
	byteFifo #(.DEPTH(FIFO_DEPTH)) txFifo (
		.PCLK(PCLK), .PRESETn(PRESETn), .push(txPush), .pushByte(txInByte),
		.pop(txPop), .popByte(txHeadByte), .full(txFull), .empty(txEmpty)
	);

	byteFifo #(.DEPTH(FIFO_DEPTH)) rxFifo (
		.PCLK(PCLK), .PRESETn(PRESETn), .push(rxPush), .pushByte(rxInByte),
		.pop(rxPop), .popByte(rxHeadByte), .full(rxFull), .empty(rxEmpty)
	);

	// Bit timing
	sclTimer timer (
		.PCLK(PCLK), .PRESETn(PRESETn), .run(run), .divider(divider), .tick(tick)
	);

	// Bus sequencer
	i2cMasterFsm master (
		.PCLK(PCLK), .PRESETn(PRESETn), .startPulse(startPulse), .cmd(cmd),
		.tick(tick), .txByte(txHeadByte), .txEmpty(txEmpty), .rxFull(rxFull),
		.sdaIn(sdaIn), .run(run), .txPop(txPop), .rxByte(rxInByte),
		.rxPush(rxPush), .status(status), .sclLow(sclLow), .sdaLow(sdaLow)
	);

endmodule

/* source/apbRegs.sv */
// APB slave register block: FIFO strobes, configuration, status, error response and interrupts
`timescale 1ns/1ps

module apbRegs import i2cPkg::*;
(
	input  logic       PCLK,
	input  logic       PRESETn,
	input  apbReq_t    apbReq,
	input  i2cByte_t   rxByte,
	input  logic       txFull,
	input  logic       txEmpty,
	input  logic       rxFull,
	input  logic       rxEmpty,
	input  i2cStatus_t status,
	output apbData_t   PRDATA,
	output logic       PREADY,
	output logic       PSLVERR,
	output logic       txPush,
	output i2cByte_t   txByte,
	output logic       rxPop,
	output logic       startPulse,
	output i2cCmd_t    cmd,
	output divider_t   divider,
	output logic       intTx,
	output logic       intRx
);
	logic access;
	logic hitTx;
	logic hitRx;
	logic hitCfg;
	logic hitDiv;
	logic hitStat;
	logic errAccess;
	logic wrAccess;
	logic rdAccess;
	logic nackSticky;

	////////////////////////////////////////////////////////////
	// Access decode
	////////////////////////////////////////////////////////////
	// Zero wait states, every access phase completes at once
	assign access = apbReq.sel && apbReq.enable;
	assign PREADY = access;

	assign hitTx = (apbReq.addr == TX_DATA_ADDR);
	assign hitRx = (apbReq.addr == RX_DATA_ADDR);
	assign hitCfg = (apbReq.addr == CONFIG_ADDR);
	assign hitDiv = (apbReq.addr == DIVIDER_ADDR);
	assign hitStat = (apbReq.addr == STATUS_ADDR);

	// Push to full TX, pop of empty RX, or unmapped offset
	assign errAccess = access && ((apbReq.write && hitTx && txFull)
		|| (!apbReq.write && hitRx && rxEmpty)
		|| !(hitTx || hitRx || hitCfg || hitDiv || hitStat));
	assign PSLVERR = errAccess;

	// Erroring accesses leave all state alone
	assign wrAccess = access && apbReq.write && !errAccess;
	assign rdAccess = access && !apbReq.write && !errAccess;

	// FIFO strobes
	assign txPush = wrAccess && hitTx;
	assign txByte = apbReq.wdata[7:0];
	assign rxPop = rdAccess && hitRx;

	// Interrupt lines
	assign intTx = txEmpty;
	assign intRx = !rxEmpty;

	////////////////////////////////////////////////////////////
	// Configuration and sticky status
	////////////////////////////////////////////////////////////
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			cmd <= '0;
			divider <= '0;
			startPulse <= 1'b0;
			nackSticky <= 1'b0;
		end
		else
		begin
			startPulse <= 1'b0;
			// Command fields frozen while a transfer runs
			if (wrAccess && hitCfg && !status.busy)
			begin
				cmd.read <= apbReq.wdata[1];
				cmd.slaveAddr <= apbReq.wdata[8:2];
				cmd.byteCount <= apbReq.wdata[12:9];
				startPulse <= apbReq.wdata[0];
			end
			if (wrAccess && hitDiv)
				divider <= apbReq.wdata[13:0];
			// New NACK wins over a clearing CONFIG write
			if (status.nack)
				nackSticky <= 1'b1;
			else if (wrAccess && hitCfg)
				nackSticky <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Read data
	////////////////////////////////////////////////////////////
	always_comb
	begin
		PRDATA = '0;
		if (rdAccess)
		begin
			case (apbReq.addr)
				RX_DATA_ADDR: PRDATA = {24'd0, rxByte};
				CONFIG_ADDR: PRDATA = {19'd0, cmd.byteCount, cmd.slaveAddr, cmd.read, 1'b0};
				DIVIDER_ADDR: PRDATA = {18'd0, divider};
				STATUS_ADDR: PRDATA = {27'd0, rxFull, rxEmpty, txEmpty, nackSticky, status.busy};
				default: PRDATA = '0;
			endcase
		end
	end

endmodule

/* source/byteFifo.sv */
// Synchronous byte FIFO with full and empty flags, used for the transmit and receive paths
`timescale 1ns/1ps

module byteFifo import i2cPkg::*;
#(
	parameter int DEPTH = 4
)
(
	input  logic     PCLK,
	input  logic     PRESETn,
	input  logic     push,
	input  i2cByte_t pushByte,
	input  logic     pop,
	output i2cByte_t popByte,
	output logic     full,
	output logic     empty
);
	// Pointer needs at least one bit, count must reach DEPTH
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	i2cByte_t mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic doPush;
	logic doPop;

	// Overflow and underflow requests are dropped
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	// Flags follow the registered occupancy
	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	// Head entry always visible
	assign popByte = mem[rdPtr];

	// Storage
	always_ff @(posedge PCLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushByte;
	end

	// Pointers and occupancy
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Wrap at DEPTH so any depth works
			if (doPush)
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			// Simultaneous push and pop keeps the count
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* source/i2cMasterFsm.sv */
// I2C master sequencer: START, address, data with acknowledge and STOP, on quarter-bit ticks
`timescale 1ns/1ps

module i2cMasterFsm import i2cPkg::*;
(
	input  logic       PCLK,
	input  logic       PRESETn,
	input  logic       startPulse,
	input  i2cCmd_t    cmd,
	input  logic       tick,
	input  i2cByte_t   txByte,
	input  logic       txEmpty,
	input  logic       rxFull,
	input  logic       sdaIn,
	output logic       run,
	output logic       txPop,
	output i2cByte_t   rxByte,
	output logic       rxPush,
	output i2cStatus_t status,
	output logic       sclLow,
	output logic       sdaLow
);
	typedef enum logic [2:0] {
		sIdle, sStart, sAddrBits, sAddrAck, sLoad, sDataBits, sDataAck, sStop
	} masterState_t;

	masterState_t state;
	// Quarter of the current bit, 0 and 1 with SCL low, 2 and 3 high
	logic [1:0] phase;
	logic [2:0] bitCnt;
	byteCount_t byteCnt;
	i2cByte_t shiftReg;
	logic readMode;
	logic ackBit;
	logic busy;
	logic nackPulse;
	logic readData;
	logic masterAck;
	logic lastByte;

	assign run = busy;
	assign status.busy = busy;
	assign status.nack = nackPulse;
	// Received byte is taken straight from the shifter
	assign rxByte = shiftReg;
	// Slave drives data bits on reads
	assign readData = (state == sDataBits) && readMode;
	// Master drives the acknowledge on reads
	assign masterAck = (state == sDataAck) && readMode;
	assign lastByte = (byteCnt == byteCount_t'(1));

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= sIdle;
			phase <= '0;
			bitCnt <= '0;
			byteCnt <= '0;
			readMode <= 1'b0;
			ackBit <= 1'b0;
			busy <= 1'b0;
			nackPulse <= 1'b0;
			txPop <= 1'b0;
			rxPush <= 1'b0;
			sclLow <= 1'b0;
			sdaLow <= 1'b0;
		end
		else
		begin
			// Single-cycle strobes
			txPop <= 1'b0;
			rxPush <= 1'b0;
			nackPulse <= 1'b0;
			// Phase wraps every four ticks in all active states
			if (tick && state != sIdle && state != sLoad)
				phase <= phase + 1'b1;
			case (state)
				sIdle:
				begin
					// Latch the command so it may change during the transfer
					if (startPulse)
					begin
						busy <= 1'b1;
						state <= sStart;
						phase <= '0;
						bitCnt <= 3'd7;
						shiftReg <= {cmd.slaveAddr, cmd.read};
						readMode <= cmd.read;
						byteCnt <= (cmd.byteCount == '0) ? byteCount_t'(1) : cmd.byteCount;
					end
				end
				sStart:
				begin
					// SDA falls while SCL is high, then SCL falls
					if (tick && phase == 2'd2)
						sdaLow <= 1'b1;
					if (tick && phase == 2'd3)
					begin
						sclLow <= 1'b1;
						state <= sAddrBits;
					end
				end
				sAddrBits, sDataBits:
				begin
					if (tick)
					begin
						case (phase)
							// Drive or release SDA with SCL low
							2'd0: sdaLow <= readData ? 1'b0 : !shiftReg[bitCnt];
							2'd1: sclLow <= 1'b0;
							// Third tick samples the slave
							2'd2:
							begin
								if (readData)
									shiftReg[bitCnt] <= sdaIn;
							end
							default:
							begin
								sclLow <= 1'b1;
								bitCnt <= bitCnt - 1'b1;
								if (bitCnt == 3'd0)
								begin
									rxPush <= readData;
									state <= (state == sAddrBits) ? sAddrAck : sDataAck;
								end
							end
						endcase
					end
				end
				sAddrAck, sDataAck:
				begin
					if (tick)
					begin
						case (phase)
							// ACK all read bytes but the last
							2'd0: sdaLow <= masterAck && !lastByte;
							2'd1: sclLow <= 1'b0;
							2'd2: ackBit <= sdaIn;
							default:
							begin
								sclLow <= 1'b1;
								if (!masterAck && ackBit)
								begin
									// Refused by the slave, finish with STOP
									nackPulse <= 1'b1;
									state <= sStop;
								end
								else if (state == sAddrAck)
									state <= sLoad;
								else if (lastByte)
									state <= sStop;
								else
								begin
									byteCnt <= byteCnt - 1'b1;
									state <= sLoad;
								end
							end
						endcase
					end
				end
				sLoad:
				begin
					// SCL stays low until the FIFO side is ready
					// then the first quarter of bit 7 is done here
					if (tick && (readMode ? !rxFull : !txEmpty))
					begin
						phase <= 2'd1;
						bitCnt <= 3'd7;
						state <= sDataBits;
						if (readMode)
							sdaLow <= 1'b0;
						else
						begin
							shiftReg <= txByte;
							sdaLow <= !txByte[7];
							txPop <= 1'b1;
						end
					end
				end
				default:
				begin
					// STOP: SDA low, SCL up, SDA up
					if (tick)
					begin
						case (phase)
							2'd0: sdaLow <= 1'b1;
							2'd1: sclLow <= 1'b0;
							2'd2: sdaLow <= 1'b0;
							default:
							begin
								busy <= 1'b0;
								state <= sIdle;
							end
						endcase
					end
				end
			endcase
		end
	end

endmodule

/* source/i2cPkg.sv */
// Shared types, APB register map and signal bundles of the APB I2C master, imported by each module
package i2cPkg;

	////////////////////////////////////////////////////////////
	// Widths with a meaning
	////////////////////////////////////////////////////////////
	typedef logic [31:0] apbAddr_t;
	typedef logic [31:0] apbData_t;
	typedef logic [7:0]  i2cByte_t;
	typedef logic [6:0]  slaveAddr_t;
	// Bytes per transfer, 1 to 15, zero runs as one
	typedef logic [3:0]  byteCount_t;
	// SCL quarter-bit divider
	typedef logic [13:0] divider_t;

	////////////////////////////////////////////////////////////
	// Register offsets
	////////////////////////////////////////////////////////////
	// Write pushes the transmit FIFO
	localparam apbAddr_t TX_DATA_ADDR = 32'd0;
	// Read pops the receive FIFO
	localparam apbAddr_t RX_DATA_ADDR = 32'd4;
	// Bit 0 start, bit 1 read, bits 8..2 slave address, bits 12..9 byte count
	localparam apbAddr_t CONFIG_ADDR  = 32'd8;
	// Bits 13..0 divider
	localparam apbAddr_t DIVIDER_ADDR = 32'd12;
	// Bit 0 busy, 1 NACK, 2 TX empty, 3 RX empty, 4 RX full
	localparam apbAddr_t STATUS_ADDR  = 32'd16;

	////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////
	// APB request from the processor side
	typedef struct packed {
		logic     sel;
		logic     enable;
		logic     write;
		apbAddr_t addr;
		apbData_t wdata;
	} apbReq_t;

	// Transfer command, latched by the master on start
	typedef struct packed {
		slaveAddr_t slaveAddr;
		logic       read;
		byteCount_t byteCount;
	} i2cCmd_t;

	// Master status, nack pulses one cycle on a missing acknowledge
	typedef struct packed {
		logic busy;
		logic nack;
	} i2cStatus_t;

endpackage

/* source/sclTimer.sv */
// Quarter-bit tick generator for the I2C master, free-running while a transfer is active
`timescale 1ns/1ps

module sclTimer import i2cPkg::*;
(
	input  logic     PCLK,
	input  logic     PRESETn,
	input  logic     run,
	input  divider_t divider,
	output logic     tick
);
	// Down-counter, sits at the reload value while stopped
	divider_t count;

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else
		begin
			// One tick per divider+1 cycles
			tick <= run && (count == '0);
			// Reload on terminal count or when idle
			if (!run || count == '0)
				count <= divider;
			else
				count <= count - 1'b1;
		end
	end

	// First tick lands divider+1 cycles after run rises
	// since the count already holds the reload value
	// and tick is registered one cycle behind terminal count
	// Four ticks make one SCL bit

endmodule

/* src.f */
source/i2cPkg.sv
source/byteFifo.sv
source/sclTimer.sv
source/i2cMasterFsm.sv
source/apbRegs.sv
source/apbI2cTop.sv
sim/i2cSlaveModel.sv
sim/tbApbI2c.sv
